// File: verilog/core_pkg.sv
// rv32 machine mode only; just the four trap csrs are numbered here and mstatus keeps only mie/mpie
package core_pkg;

    // data and instruction word
    typedef logic [31:0] word_t;

    // byte address, pc uses this
    typedef logic [31:0] addr_t;

    // csr number field of the system opcode
    typedef logic [11:0] csr_addr_t;

    // machine csr numbers from the privileged spec
    localparam csr_addr_t CSR_MSTATUS = 12'h300;
    localparam csr_addr_t CSR_MTVEC   = 12'h305;
    localparam csr_addr_t CSR_MEPC    = 12'h341;
    localparam csr_addr_t CSR_MCAUSE  = 12'h342;

    // environment call from m-mode
    localparam word_t MCAUSE_ECALL_M = 32'd11;

    // mstatus bit positions
    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;

endpackage

// File: verilog/ctrl_pkg.sv
// decoded control word for a single-cycle core; no memory option, so loads and stores cannot be expressed
package ctrl_pkg;

    // operand pair fed to the alu
    typedef enum logic [1:0] {
        SRC_NONE    = 2'b00,
        SRC_PC_IMM  = 2'b01,
        SRC_RS1_RS2 = 2'b10,
        SRC_RS1_IMM = 2'b11
    } src_sel_e;

    // alu function, modified by alt, sgn and inv
    typedef enum logic [2:0] {
        ALU_ADD    = 3'b000,
        ALU_AND    = 3'b001,
        ALU_XOR    = 3'b010,
        ALU_SLL    = 3'b011,
        ALU_SRL    = 3'b100,
        ALU_LT     = 3'b101,
        ALU_EQ     = 3'b110,
        ALU_PASS_B = 3'b111
    } alu_op_e;

    // next pc source
    // trap covers both ecall (mtvec) and mret (mepc)
    typedef enum logic [1:0] {
        PC_PLUS4   = 2'b00,
        PC_IMM     = 2'b01,
        PC_RS1_IMM = 2'b10,
        PC_TRAP    = 2'b11
    } pc_sel_e;

    // system instruction kind
    typedef enum logic [1:0] {
        SYS_NONE  = 2'b00,
        SYS_ECALL = 2'b01,
        SYS_MRET  = 2'b10
    } sys_op_e;

    // one control word per instruction, 18 bits
    typedef struct packed {
        logic     rf_wen;
        src_sel_e src_sel;
        alu_op_e  alu_op;
        // sub, or, arithmetic right shift
        logic     alt;
        // signed compare
        logic     sgn;
        // negate compare result, bne and bge forms
        logic     inv;
        logic     branch;
        pc_sel_e  pc_sel;
        // writeback is pc+4
        logic     link;
        logic     csr_wen;
        logic     csr_ren;
        // csrrs instead of csrrw
        logic     csr_set;
        sys_op_e  sys;
    } ctrl_t;

    // all enables off, pc+4
    localparam ctrl_t CTRL_NOP = '0;

endpackage

// File: verilog/idu.sv
// index fields truncate to REG_ADDR_W so x16-x31 alias in rv32e; unknown opcodes become no-ops, no illegal trap
`timescale 1ns/100ps

module idu #(
    parameter int REG_ADDR_W = 4
) (
    input  core_pkg::word_t       inst,
    output logic [REG_ADDR_W-1:0] rs1,
    output logic [REG_ADDR_W-1:0] rs2,
    output logic [REG_ADDR_W-1:0] rd,
    output core_pkg::word_t       imm,
    output core_pkg::csr_addr_t   csr_addr,
    output ctrl_pkg::ctrl_t       ctrl
);

    // major opcodes this core knows
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic            is_arith;
    core_pkg::word_t imm_i;
    core_pkg::word_t imm_b;
    core_pkg::word_t imm_u;
    core_pkg::word_t imm_j;

    assign opcode   = inst[6:0];
    assign funct3   = inst[14:12];
    assign rd       = inst[7 +: REG_ADDR_W];
    assign rs1      = inst[15 +: REG_ADDR_W];
    assign rs2      = inst[20 +: REG_ADDR_W];
    assign csr_addr = inst[31:20];

    // sign-extended immediate formats
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        ctrl     = ctrl_pkg::CTRL_NOP;
        imm      = imm_i;
        is_arith = 1'b0;
        case (opcode)
            OPC_LUI: begin
                // alu just forwards imm
                ctrl.rf_wen  = 1'b1;
                ctrl.src_sel = ctrl_pkg::SRC_RS1_IMM;
                ctrl.alu_op  = ctrl_pkg::ALU_PASS_B;
                imm          = imm_u;
            end
            OPC_AUIPC: begin
                ctrl.rf_wen  = 1'b1;
                ctrl.src_sel = ctrl_pkg::SRC_PC_IMM;
                imm          = imm_u;
            end
            OPC_JAL: begin
                ctrl.rf_wen = 1'b1;
                ctrl.link   = 1'b1;
                ctrl.pc_sel = ctrl_pkg::PC_IMM;
                imm         = imm_j;
            end
            OPC_JALR: begin
                ctrl.rf_wen = 1'b1;
                ctrl.link   = 1'b1;
                ctrl.pc_sel = ctrl_pkg::PC_RS1_IMM;
            end
            OPC_BRANCH: begin
                ctrl.src_sel = ctrl_pkg::SRC_RS1_RS2;
                ctrl.branch  = 1'b1;
                ctrl.pc_sel  = ctrl_pkg::PC_IMM;
                imm          = imm_b;
                case (funct3)
                    3'b000: ctrl.alu_op = ctrl_pkg::ALU_EQ;
                    3'b001: begin
                        ctrl.alu_op = ctrl_pkg::ALU_EQ;
                        ctrl.inv    = 1'b1;
                    end
                    3'b100: begin
                        ctrl.alu_op = ctrl_pkg::ALU_LT;
                        ctrl.sgn    = 1'b1;
                    end
                    3'b101: begin
                        ctrl.alu_op = ctrl_pkg::ALU_LT;
                        ctrl.sgn    = 1'b1;
                        ctrl.inv    = 1'b1;
                    end
                    3'b110: ctrl.alu_op = ctrl_pkg::ALU_LT;
                    3'b111: begin
                        ctrl.alu_op = ctrl_pkg::ALU_LT;
                        ctrl.inv    = 1'b1;
                    end
                    // funct3 010/011 reserved
                    default: ctrl = ctrl_pkg::CTRL_NOP;
                endcase
            end
            OPC_OP_IMM: begin
                is_arith     = 1'b1;
                ctrl.src_sel = ctrl_pkg::SRC_RS1_IMM;
            end
            OPC_OP: begin
                is_arith     = 1'b1;
                ctrl.src_sel = ctrl_pkg::SRC_RS1_RS2;
            end
            OPC_SYSTEM: begin
                case (funct3)
                    3'b000: begin
                        if (inst[31:20] == 12'h000) begin
                            ctrl.sys    = ctrl_pkg::SYS_ECALL;
                            ctrl.pc_sel = ctrl_pkg::PC_TRAP;
                        end else if (inst[31:20] == 12'h302) begin
                            ctrl.sys    = ctrl_pkg::SYS_MRET;
                            ctrl.pc_sel = ctrl_pkg::PC_TRAP;
                        end
                    end
                    3'b001: begin
                        ctrl.rf_wen  = 1'b1;
                        ctrl.csr_ren = 1'b1;
                        ctrl.csr_wen = 1'b1;
                    end
                    3'b010: begin
                        // csrrs with rs1 field zero is a pure read
                        ctrl.rf_wen  = 1'b1;
                        ctrl.csr_ren = 1'b1;
                        ctrl.csr_set = 1'b1;
                        ctrl.csr_wen = (inst[19:15] != 5'd0);
                    end
                    default: ctrl = ctrl_pkg::CTRL_NOP;
                endcase
            end
            default: ctrl = ctrl_pkg::CTRL_NOP;
        endcase

        // funct3 map shared by op and op-imm
        if (is_arith) begin
            ctrl.rf_wen = 1'b1;
            case (funct3)
                3'b000: begin
                    // bit 30 is immediate data for addi
                    ctrl.alu_op = ctrl_pkg::ALU_ADD;
                    ctrl.alt    = (opcode == OPC_OP) & inst[30];
                end
                3'b001: ctrl.alu_op = ctrl_pkg::ALU_SLL;
                3'b010: begin
                    ctrl.alu_op = ctrl_pkg::ALU_LT;
                    ctrl.sgn    = 1'b1;
                end
                3'b011: ctrl.alu_op = ctrl_pkg::ALU_LT;
                3'b100: ctrl.alu_op = ctrl_pkg::ALU_XOR;
                3'b101: begin
                    ctrl.alu_op = ctrl_pkg::ALU_SRL;
                    ctrl.alt    = inst[30];
                end
                3'b110: begin
                    ctrl.alu_op = ctrl_pkg::ALU_AND;
                    ctrl.alt    = 1'b1;
                end
                default: ctrl.alu_op = ctrl_pkg::ALU_AND;
            endcase
        end
    end

endmodule

// File: verilog/regfile.sv
// contents are undefined after reset and writes are dropped while rst_n is low; x0 reads zero
`timescale 1ns/100ps

module regfile #(
    parameter int REG_ADDR_W = 4
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  wen,
    input  logic [REG_ADDR_W-1:0] waddr,
    input  core_pkg::word_t       wdata,
    input  logic [REG_ADDR_W-1:0] raddr1,
    input  logic [REG_ADDR_W-1:0] raddr2,
    output core_pkg::word_t       rdata1,
    output core_pkg::word_t       rdata2
);

    // entry 0 exists but is never written or read
    core_pkg::word_t regs [2**REG_ADDR_W];

    // single write port, rd of the retiring instruction
    always_ff @(posedge clk) begin
        if (wen && rst_n && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // combinational reads, x0 forced to zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: verilog/csr_file.sv
// only mstatus, mtvec, mepc and mcause exist; other addresses read zero and ignore writes, trap beats write
`timescale 1ns/100ps

module csr_file (
    input  logic                clk,
    input  logic                rst_n,
    input  core_pkg::csr_addr_t addr,
    input  logic                wen,
    input  core_pkg::word_t     wdata,
    output core_pkg::word_t     rdata,
    input  logic                trap,
    input  logic                ret,
    input  core_pkg::addr_t     pc,
    output core_pkg::addr_t     mtvec,
    output core_pkg::addr_t     mepc
);

    core_pkg::word_t mstatus_q;
    core_pkg::word_t mtvec_q;
    core_pkg::word_t mepc_q;
    core_pkg::word_t mcause_q;

    // addressed read, old value for csrrw/csrrs
    always_comb begin
        case (addr)
            core_pkg::CSR_MSTATUS: rdata = mstatus_q;
            core_pkg::CSR_MTVEC:   rdata = mtvec_q;
            core_pkg::CSR_MEPC:    rdata = mepc_q;
            core_pkg::CSR_MCAUSE:  rdata = mcause_q;
            default:               rdata = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mstatus_q <= '0;
            mtvec_q   <= '0;
            mepc_q    <= '0;
            mcause_q  <= '0;
        end else if (trap) begin
            // ecall entry
            mepc_q   <= pc;
            mcause_q <= core_pkg::MCAUSE_ECALL_M;
            mstatus_q[core_pkg::MSTATUS_MPIE_BIT] <= mstatus_q[core_pkg::MSTATUS_MIE_BIT];
            mstatus_q[core_pkg::MSTATUS_MIE_BIT]  <= 1'b0;
        end else if (ret) begin
            // mret, mie back from mpie
            mstatus_q[core_pkg::MSTATUS_MIE_BIT] <= mstatus_q[core_pkg::MSTATUS_MPIE_BIT];
        end else if (wen) begin
            case (addr)
                core_pkg::CSR_MSTATUS: mstatus_q <= wdata;
                core_pkg::CSR_MTVEC:   mtvec_q   <= wdata;
                core_pkg::CSR_MEPC:    mepc_q    <= wdata;
                core_pkg::CSR_MCAUSE:  mcause_q  <= wdata;
                default:               ;
            endcase
        end
    end

    // redirect targets for exu
    assign mtvec = mtvec_q;
    assign mepc  = mepc_q;

endmodule

// File: verilog/exu.sv
// mtvec is direct mode only and trap targets drop their low two bits; no misaligned-fetch exception
`timescale 1ns/100ps

module exu #(
    parameter int              REG_ADDR_W = 4,
    parameter core_pkg::addr_t RESET_PC   = 32'h8000_0000
) (
    input  logic            clk,
    input  logic            rst_n,
    input  ctrl_pkg::ctrl_t ctrl,
    input  core_pkg::word_t rs1_d,
    input  core_pkg::word_t rs2_d,
    input  core_pkg::word_t imm,
    input  core_pkg::word_t csr_rdata,
    input  core_pkg::addr_t mtvec,
    input  core_pkg::addr_t mepc,
    output core_pkg::addr_t pc,
    output core_pkg::word_t wb_data,
    output logic            csr_wen,
    output core_pkg::word_t csr_wdata,
    output logic            trap,
    output logic            ret
);

    core_pkg::word_t op_a;
    core_pkg::word_t op_b;
    core_pkg::word_t alu_res;
    logic            cmp;
    core_pkg::addr_t pc_plus4;
    core_pkg::addr_t pc_imm;
    core_pkg::addr_t rs1_imm;
    core_pkg::addr_t next_pc;

    // only rv32e (4) and rv32i (5) index widths make sense
    if (REG_ADDR_W < 4 || REG_ADDR_W > 5) begin : g_bad_width
        $error("REG_ADDR_W must be 4 or 5");
    end

    // operand pair
    always_comb begin
        case (ctrl.src_sel)
            ctrl_pkg::SRC_PC_IMM:  {op_a, op_b} = {pc, imm};
            ctrl_pkg::SRC_RS1_RS2: {op_a, op_b} = {rs1_d, rs2_d};
            ctrl_pkg::SRC_RS1_IMM: {op_a, op_b} = {rs1_d, imm};
            default:               {op_a, op_b} = '0;
        endcase
    end

    // compare core, signed or unsigned less-than
    assign cmp = ctrl.sgn ? ($signed(op_a) < $signed(op_b)) : (op_a < op_b);

    always_comb begin
        case (ctrl.alu_op)
            ctrl_pkg::ALU_ADD: alu_res = ctrl.alt ? (op_a - op_b) : (op_a + op_b);
            ctrl_pkg::ALU_AND: alu_res = ctrl.alt ? (op_a | op_b) : (op_a & op_b);
            ctrl_pkg::ALU_XOR: alu_res = op_a ^ op_b;
            ctrl_pkg::ALU_SLL: alu_res = op_a << op_b[4:0];
            ctrl_pkg::ALU_SRL: begin
                alu_res = ctrl.alt ? core_pkg::word_t'($signed(op_a) >>> op_b[4:0])
                                   : (op_a >> op_b[4:0]);
            end
            ctrl_pkg::ALU_LT:  alu_res = {31'b0, cmp ^ ctrl.inv};
            ctrl_pkg::ALU_EQ:  alu_res = {31'b0, (op_a == op_b) ^ ctrl.inv};
            default:           alu_res = op_b;
        endcase
    end

    assign pc_plus4 = pc + 32'd4;
    assign pc_imm   = pc + imm;
    assign rs1_imm  = rs1_d + imm;

    // writeback, csr read wins over link
    assign wb_data = ctrl.csr_ren ? csr_rdata : (ctrl.link ? pc_plus4 : alu_res);

    // csrrs ors rs1 into the old value
    assign csr_wen   = ctrl.csr_wen;
    assign csr_wdata = ctrl.csr_set ? (csr_rdata | rs1_d) : rs1_d;
    assign trap      = (ctrl.sys == ctrl_pkg::SYS_ECALL);
    assign ret       = (ctrl.sys == ctrl_pkg::SYS_MRET);

    always_comb begin
        case (ctrl.pc_sel)
            // not-taken branch falls through
            ctrl_pkg::PC_IMM:     next_pc = (ctrl.branch && !alu_res[0]) ? pc_plus4 : pc_imm;
            ctrl_pkg::PC_RS1_IMM: next_pc = {rs1_imm[31:1], 1'b0};
            ctrl_pkg::PC_TRAP:    next_pc = ret ? {mepc[31:2], 2'b00} : {mtvec[31:2], 2'b00};
            default:              next_pc = pc_plus4;
        endcase
    end

    // one instruction retires per edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else begin
            pc <= next_pc;
        end
    end

endmodule

// File: verilog/cpu_top.sv
// inst must answer combinationally for the current pc and be held at a no-op while rst_n is low
`timescale 1ns/100ps

module cpu_top #(
    parameter int              REG_ADDR_W = 4,
    parameter core_pkg::addr_t RESET_PC   = 32'h8000_0000
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  core_pkg::word_t       inst,
    output core_pkg::addr_t       pc,
    output logic                  wb_en,
    output logic [REG_ADDR_W-1:0] wb_addr,
    output core_pkg::word_t       wb_data
);

    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rd;
    core_pkg::word_t       imm;
    core_pkg::csr_addr_t   csr_addr;
    ctrl_pkg::ctrl_t       ctrl;
    core_pkg::word_t       rs1_d;
    core_pkg::word_t       rs2_d;
    core_pkg::word_t       csr_rdata;
    core_pkg::word_t       csr_wdata;
    logic                  csr_wen;
    logic                  trap;
    logic                  ret;
    core_pkg::addr_t       mtvec;
    core_pkg::addr_t       mepc;

    // retire trace is the register write port
    assign wb_en   = ctrl.rf_wen;
    assign wb_addr = rd;

    idu #(
        .REG_ADDR_W (REG_ADDR_W)
    ) u_idu (
        .inst     (inst),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .imm      (imm),
        .csr_addr (csr_addr),
        .ctrl     (ctrl)
    );

    regfile #(
        .REG_ADDR_W (REG_ADDR_W)
    ) u_regfile (
        .clk    (clk),
        .rst_n  (rst_n),
        .wen    (wb_en),
        .waddr  (rd),
        .wdata  (wb_data),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .rdata1 (rs1_d),
        .rdata2 (rs2_d)
    );

    csr_file u_csr (
        .clk   (clk),
        .rst_n (rst_n),
        .addr  (csr_addr),
        .wen   (csr_wen),
        .wdata (csr_wdata),
        .rdata (csr_rdata),
        .trap  (trap),
        .ret   (ret),
        .pc    (pc),
        .mtvec (mtvec),
        .mepc  (mepc)
    );

    exu #(
        .REG_ADDR_W (REG_ADDR_W),
        .RESET_PC   (RESET_PC)
    ) u_exu (
        .clk       (clk),
        .rst_n     (rst_n),
        .ctrl      (ctrl),
        .rs1_d     (rs1_d),
        .rs2_d     (rs2_d),
        .imm       (imm),
        .csr_rdata (csr_rdata),
        .mtvec     (mtvec),
        .mepc      (mepc),
        .pc        (pc),
        .wb_data   (wb_data),
        .csr_wen   (csr_wen),
        .csr_wdata (csr_wdata),
        .trap      (trap),
        .ret       (ret)
    );

endmodule

// File: testbench/cpu_props.sv
// assumes one retire per clock and the register index width that cpu_top passes down
`timescale 1ns/100ps

module cpu_props #(
    parameter int              REG_ADDR_W = 4,
    parameter core_pkg::addr_t RESET_PC   = 32'h8000_0000
) (
    input logic                  clk,
    input logic                  rst_n,
    input core_pkg::addr_t       pc,
    input logic                  wb_en,
    input logic [REG_ADDR_W-1:0] wb_addr,
    input core_pkg::word_t       wb_data,
    input core_pkg::word_t       x0_q
);

    // count of failed assertions
    int failures = 0;

    // no compressed instructions, so pc stays word aligned
    a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00)
        else begin
            failures++;
            $error("pc is not word aligned");
        end

    a_reset_pc: assert property (@(posedge clk) !rst_n |-> pc == RESET_PC)
        else begin
            failures++;
            $error("pc differs from the reset value during reset");
        end

    a_wb_known: assert property (@(posedge clk) disable iff (!rst_n)
                                 wb_en |-> !$isunknown(wb_data))
        else begin
            failures++;
            $error("write data has unknown bits");
        end

    // x0 storage is left alone by a write to x0
    a_x0_kept: assert property (@(posedge clk) disable iff (!rst_n)
                                (wb_en && wb_addr == '0) |=> (x0_q === $past(x0_q)))
        else begin
            failures++;
            $error("a write to x0 changed the stored x0 entry");
        end

endmodule

bind cpu_top cpu_props #(
    .REG_ADDR_W (REG_ADDR_W),
    .RESET_PC   (RESET_PC)
) u_props (
    .clk     (clk),
    .rst_n   (rst_n),
    .pc      (pc),
    .wb_en   (wb_en),
    .wb_addr (wb_addr),
    .wb_data (wb_data),
    .x0_q    (u_regfile.regs[0])
);

// File: testbench/tb_cpu.sv
// expects rv32e at reset pc 80000000 with a fixed pc sequence from testbench/prog_golden.hex
`timescale 1ns/100ps

module tb_cpu;

    localparam int              REG_ADDR_W = 4;
    localparam core_pkg::addr_t RESET_PC   = 32'h8000_0000;
    // each golden record holds inst, pc, wb_en, wb_addr and wb_data
    localparam int              NREC       = 40;
    localparam int              FIELDS     = 5;
    localparam int              RST_CYCLES = 16;
    // one record retires per cycle with reset and slack added
    localparam int              TIMEOUT_CYCLES = NREC + RST_CYCLES + 20;
    // addi x0, x0, 0
    localparam core_pkg::word_t NOP        = 32'h0000_0013;

    logic                  clk;
    logic                  rst_n;
    core_pkg::word_t       inst;
    core_pkg::addr_t       pc;
    logic                  wb_en;
    logic [REG_ADDR_W-1:0] wb_addr;
    core_pkg::word_t       wb_data;

    logic [31:0] golden [0:NREC*FIELDS-1];
    int          errors = 0;
    int          checks = 0;
    int          rec = 0;
    int          cycles = 0;

    cpu_top #(
        .REG_ADDR_W (REG_ADDR_W),
        .RESET_PC   (RESET_PC)
    ) uut (
        .clk     (clk),
        .rst_n   (rst_n),
        .inst    (inst),
        .pc      (pc),
        .wb_en   (wb_en),
        .wb_addr (wb_addr),
        .wb_data (wb_data)
    );

    // 8 ns clock
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // counts and reports mismatches
    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h (record %0d)",
                     name, actual, expected, rec);
        end
    endtask

    // cycle budget
    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    initial begin
        wait (cycles >= TIMEOUT_CYCLES);
        $display("timeout: the program did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("errors: %0d, checks: %0d", errors, checks);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        rst_n = 1'b1;
        inst  = NOP;
        $readmemh("testbench/prog_golden.hex", golden);
        // an unloaded first word means the file is missing
        if ($isunknown(golden[0]) || golden[0] == 32'h0) begin
            errors++;
            $display("golden file testbench/prog_golden.hex is missing or empty");
        end

        // async reset asserted before the first rising edge
        #1 rst_n = 1'b0;
        repeat (RST_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        // pc is checked before the fetch and the trace after decode settles
        for (rec = 0; rec < NREC; rec++) begin
            compare_value("pc", pc, golden[rec*FIELDS+1]);
            inst = golden[rec*FIELDS];
            #1;
            compare_value("wb_en", 32'(wb_en), golden[rec*FIELDS+2]);
            // addr and data only mean something on a write
            if (golden[rec*FIELDS+2] != 32'h0) begin
                compare_value("wb_addr", 32'(wb_addr), golden[rec*FIELDS+3]);
                compare_value("wb_data", wb_data, golden[rec*FIELDS+4]);
            end
            @(negedge clk);
        end
        inst = NOP;

        if (uut.u_props.failures != 0) begin
            errors += uut.u_props.failures;
            $display("%0d assertion failures in cpu_props", uut.u_props.failures);
        end

        $display("errors: %0d, checks: %0d", errors, checks);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: testbench/prog_golden.hex
// columns: instruction, expected pc, expected wb_en, expected wb_addr, expected wb_data
// one record per retired instruction; addr and data are don't-care when wb_en is 0
00500093 80000000 1 1 00000005 // addi x1, x0, 5
FFD00113 80000004 1 2 FFFFFFFD // addi x2, x0, -3
002081B3 80000008 1 3 00000002 // add x3, x1, x2
40208233 8000000C 1 4 00000008 // sub x4, x1, x2
0020F2B3 80000010 1 5 00000005 // and x5, x1, x2
0020E333 80000014 1 6 FFFFFFFD // or x6, x1, x2
0020C3B3 80000018 1 7 FFFFFFF8 // xor x7, x1, x2
00409413 8000001C 1 8 00000050 // slli x8, x1, 4
001154B3 80000020 1 9 07FFFFFF // srl x9, x2, x1
40115513 80000024 1 A FFFFFFFE // srai x10, x2, 1
001125B3 80000028 1 B 00000001 // slt x11, x2, x1
00113633 8000002C 1 C 00000000 // sltu x12, x2, x1
123456B7 80000030 1 D 12345000 // lui x13, 0x12345
00001717 80000034 1 E 80001034 // auipc x14, 1
00108463 80000038 0 0 00000000 // beq x1, x1, +8 taken
00208463 80000040 0 0 00000000 // beq x1, x2, +8 not taken
00209463 80000044 0 0 00000000 // bne x1, x2, +8 taken
00109463 8000004C 0 0 00000000 // bne x1, x1, +8 not taken
00114463 80000050 0 0 00000000 // blt x2, x1, +8 taken
0020C463 80000058 0 0 00000000 // blt x1, x2, +8 not taken
0020D463 8000005C 0 0 00000000 // bge x1, x2, +8 taken
00115463 80000064 0 0 00000000 // bge x2, x1, +8 not taken
0020E463 80000068 0 0 00000000 // bltu x1, x2, +8 taken
00116463 80000070 0 0 00000000 // bltu x2, x1, +8 not taken
00117463 80000074 0 0 00000000 // bgeu x2, x1, +8 taken
0020F463 8000007C 0 0 00000000 // bgeu x1, x2, +8 not taken
010007EF 80000080 1 F 80000084 // jal x15, +16
00000197 80000090 1 3 80000090 // auipc x3, 0
021180E7 80000094 1 1 80000098 // jalr x1, 0x21(x3), bit 0 cleared
80000237 800000B0 1 4 80000000 // lui x4, 0x80000
10020213 800000B4 1 4 80000100 // addi x4, x4, 0x100
305212F3 800000B8 1 5 00000000 // csrrw x5, mtvec, x4
30502373 800000BC 1 6 80000100 // csrrs x6, mtvec, x0
00700013 800000C0 1 0 00000007 // addi x0, x0, 7
000003B3 800000C4 1 7 00000000 // add x7, x0, x0
00000073 800000C8 0 0 00000000 // ecall
34102473 80000100 1 8 800000C8 // csrrs x8, mepc, x0
342024F3 80000104 1 9 0000000B // csrrs x9, mcause, x0
30200073 80000108 0 0 00000000 // mret
00000073 800000C8 0 0 00000000 // ecall again at the return address

// File: flist.f
verilog/core_pkg.sv
verilog/ctrl_pkg.sv
verilog/idu.sv
verilog/regfile.sv
verilog/csr_file.sv
verilog/exu.sv
verilog/cpu_top.sv
testbench/cpu_props.sv
testbench/tb_cpu.sv

// File: run.sh
#!/bin/bash
# build and run the cpu testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_cpu -o sim_cpu \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

# assertion errors must not stop the run before the testbench summary
./obj_dir/sim_cpu +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

grep -qFx "Finished with errors" sim.log && { echo "simulation failed"; exit 1; }
grep -qFx "Finished with no errors" sim.log || { echo "simulation did not complete"; exit 1; }
echo "simulation passed"
exit 0
